// ==== compile.f ====
+incdir+design
+incdir+verif
design/commit_trace_pkg.sv
design/commit_intake.sv
design/commit_lane.sv
design/commit_order.sv
design/commit_trace_top.sv
verif/commit_trace_tb.sv

// ==== design/commit_intake.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "commit_trace_macros.svh"

module commit_intake (
    input  logic                                              aclk,
    input  logic                                              rst,
    input  commit_trace_pkg::commit_in_t  [`COMMIT_LANES-1:0] commit_i,
    output commit_trace_pkg::commit_rec_t [`COMMIT_LANES-1:0] stamped_o,
    output logic [`TIMER_W-1:0]                               cycle_cnt_o
);

    logic [`TIMER_W-1:0] timer_q;

    // free running, counts every edge out of reset
    always_ff @(posedge aclk) begin
        if (rst) begin
            timer_q <= '0;
        end else begin
            timer_q <= timer_q + `TIMER_W'(1);
        end
    end

    assign cycle_cnt_o = timer_q;

    always_comb begin
        for (int i = 0; i < `COMMIT_LANES; i++) begin
            stamped_o[i].valid        = commit_i[i].valid;
            stamped_o[i].cnt_inst     = commit_i[i].cnt_inst;
            stamped_o[i].pc           = commit_i[i].pc;
            stamped_o[i].inst         = commit_i[i].inst;
            stamped_o[i].rf_wen       = commit_i[i].rf_wen;
            // zero extend register number into the destination field
            stamped_o[i].wdest        = {{(`WDEST_W-`REG_NUM_W){1'b0}}, commit_i[i].rf_wnum};
            stamped_o[i].rf_wdata     = commit_i[i].rf_wdata;
            stamped_o[i].ld_en        = commit_i[i].ld_en;
            stamped_o[i].ld_paddr     = commit_i[i].ld_paddr;
            stamped_o[i].ld_vaddr     = commit_i[i].ld_vaddr;
            stamped_o[i].st_en        = commit_i[i].st_en;
            stamped_o[i].st_paddr     = commit_i[i].st_paddr;
            stamped_o[i].st_vaddr     = commit_i[i].st_vaddr;
            stamped_o[i].st_data      = commit_i[i].st_data;
            stamped_o[i].csr_rstat_en = commit_i[i].csr_rstat_en;
            stamped_o[i].csr_data     = commit_i[i].csr_data;
            stamped_o[i].excp_flush   = commit_i[i].excp_flush;
            stamped_o[i].ertn         = commit_i[i].ertn;
            stamped_o[i].ecode        = commit_i[i].ecode;
            stamped_o[i].timer        = timer_q;   // value before the sampling edge
        end
    end

endmodule

`default_nettype wire

// ==== design/commit_lane.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "commit_trace_macros.svh"

module commit_lane (
    input  logic                          aclk,
    input  logic                          rst,
    input  commit_trace_pkg::commit_rec_t rec_i,
    output commit_trace_pkg::commit_rec_t rec_o,
    output logic [`LANE_CNT_W-1:0]        lane_cnt_o
);

    commit_trace_pkg::commit_rec_t rec_q;
    logic [`LANE_CNT_W-1:0]        cnt_q;

    // whole record cleared so no stale valid or enable after reset
    always_ff @(posedge aclk) begin
        if (rst) begin
            rec_q <= '0;
        end else begin
            rec_q <= rec_i;
        end
    end

    // counts on the edge that registers the record
    always_ff @(posedge aclk) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (rec_i.valid) begin
            cnt_q <= cnt_q + `LANE_CNT_W'(1);   // wraps
        end
    end

    assign rec_o      = rec_q;
    assign lane_cnt_o = cnt_q;

endmodule

`default_nettype wire

// ==== design/commit_order.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "commit_trace_macros.svh"

module commit_order (
    input  logic                                              aclk,
    input  logic                                              rst,
    input  commit_trace_pkg::commit_rec_t [`COMMIT_LANES-1:0] lane_i,
    output logic                                              order_index_o,
    output commit_trace_pkg::excp_event_t                     excp_o,
    output commit_trace_pkg::mem_event_t                      load_o,
    output commit_trace_pkg::mem_event_t                      store_o,
    output logic [`TIMER_W-1:0]                               instr_cnt_o
);

    localparam int VCNT_W = $clog2(`COMMIT_LANES + 1);

    logic                pc0_lt_pc1;
    logic [VCNT_W-1:0]   n_valid;
    logic [`TIMER_W-1:0] instr_cnt_q;

    // lower pc is older in program order
    assign pc0_lt_pc1 = lane_i[0].pc < lane_i[1].pc;

    // lane 0 first unless lane 1 is valid and not behind it
    assign order_index_o = !pc0_lt_pc1 && lane_i[1].valid;

    always_comb begin
        excp_o.eret  = lane_i[0].ertn;
        excp_o.cause = lane_i[0].ecode;   // always lane 0
        if (pc0_lt_pc1) begin
            if (lane_i[0].excp_flush) begin
                excp_o.valid = lane_i[0].excp_flush;
                excp_o.pc    = lane_i[0].pc;
                excp_o.inst  = lane_i[0].inst;
            end else begin
                excp_o.valid = lane_i[1].excp_flush;
                excp_o.pc    = lane_i[1].pc;
                excp_o.inst  = lane_i[1].inst;
            end
        end else begin
            if (lane_i[1].excp_flush) begin
                excp_o.valid = lane_i[1].excp_flush;
                excp_o.pc    = lane_i[1].pc;
                excp_o.inst  = lane_i[1].inst;
            end else begin
                excp_o.valid = lane_i[0].excp_flush;
                excp_o.pc    = lane_i[0].pc;
                excp_o.inst  = lane_i[0].inst;
            end
        end
    end

    // memory events only from lane 0
    always_comb begin
        load_o.en     = |lane_i[0].ld_en;
        load_o.paddr  = lane_i[0].ld_paddr;
        load_o.vaddr  = lane_i[0].ld_vaddr;
        load_o.data   = '0;
        store_o.en    = |lane_i[0].st_en;
        store_o.paddr = lane_i[0].st_paddr;
        store_o.vaddr = lane_i[0].st_vaddr;
        store_o.data  = lane_i[0].st_data;
    end

    always_comb begin
        n_valid = '0;
        for (int i = 0; i < `COMMIT_LANES; i++) begin
            n_valid = n_valid + VCNT_W'(lane_i[i].valid);
        end
    end

    // one cycle behind the lane records
    always_ff @(posedge aclk) begin
        if (rst) begin
            instr_cnt_q <= '0;
        end else begin
            instr_cnt_q <= instr_cnt_q + `TIMER_W'(n_valid);
        end
    end

    assign instr_cnt_o = instr_cnt_q;

endmodule

`default_nettype wire

// ==== design/commit_trace_macros.svh ====
`ifndef COMMIT_TRACE_MACROS_SVH
`define COMMIT_TRACE_MACROS_SVH

// commit lanes per cycle
`define COMMIT_LANES 2

// address and data word
`define XLEN 32

`define REG_NUM_W 5   // architectural register number
`define WDEST_W   8   // widened destination field

// cycle timer, instruction count
`define TIMER_W 64

`define ECODE_W 6

// load/store byte enable vector
`define LSU_EN_W 8

`define LANE_CNT_W 32

`endif

// ==== design/commit_trace_pkg.sv ====
`default_nettype none
`include "commit_trace_macros.svh"

package commit_trace_pkg;

    // one lane as the backend offers it
    typedef struct packed {
        logic                  valid;
        logic                  cnt_inst;      // counter read instruction
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      inst;
        logic                  rf_wen;
        logic [`REG_NUM_W-1:0] rf_wnum;
        logic [`XLEN-1:0]      rf_wdata;
        logic [`LSU_EN_W-1:0]  ld_en;
        logic [`XLEN-1:0]      ld_paddr;
        logic [`XLEN-1:0]      ld_vaddr;
        logic [`LSU_EN_W-1:0]  st_en;
        logic [`XLEN-1:0]      st_paddr;
        logic [`XLEN-1:0]      st_vaddr;
        logic [`XLEN-1:0]      st_data;
        logic                  csr_rstat_en;
        logic [`XLEN-1:0]      csr_data;
        logic                  excp_flush;
        logic                  ertn;
        logic [`ECODE_W-1:0]   ecode;
    } commit_in_t;

    // stamped record, wdest replaces rf_wnum
    typedef struct packed {
        logic                  valid;
        logic                  cnt_inst;
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      inst;
        logic                  rf_wen;
        logic [`WDEST_W-1:0]   wdest;
        logic [`XLEN-1:0]      rf_wdata;
        logic [`LSU_EN_W-1:0]  ld_en;
        logic [`XLEN-1:0]      ld_paddr;
        logic [`XLEN-1:0]      ld_vaddr;
        logic [`LSU_EN_W-1:0]  st_en;
        logic [`XLEN-1:0]      st_paddr;
        logic [`XLEN-1:0]      st_vaddr;
        logic [`XLEN-1:0]      st_data;
        logic                  csr_rstat_en;
        logic [`XLEN-1:0]      csr_data;
        logic                  excp_flush;
        logic                  ertn;
        logic [`ECODE_W-1:0]   ecode;
        logic [`TIMER_W-1:0]   timer;         // cycle timer at sampling
    } commit_rec_t;

    typedef struct packed {
        logic                valid;
        logic                eret;
        logic [`ECODE_W-1:0] cause;
        logic [`XLEN-1:0]    pc;
        logic [`XLEN-1:0]    inst;
    } excp_event_t;

    // data is zero for loads
    typedef struct packed {
        logic             en;
        logic [`XLEN-1:0] paddr;
        logic [`XLEN-1:0] vaddr;
        logic [`XLEN-1:0] data;
    } mem_event_t;

endpackage

`default_nettype wire

// ==== design/commit_trace_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "commit_trace_macros.svh"

module commit_trace_top (
    input  logic                                              aclk,
    input  logic                                              rst,
    input  commit_trace_pkg::commit_in_t  [`COMMIT_LANES-1:0] commit_i,
    output logic [`TIMER_W-1:0]                               cycle_cnt_o,
    output logic                                              order_index_o,
    output commit_trace_pkg::excp_event_t                     excp_o,
    output commit_trace_pkg::mem_event_t                      load_o,
    output commit_trace_pkg::mem_event_t                      store_o,
    output logic [`TIMER_W-1:0]                               instr_cnt_o,
    // debug write-back view of each lane
    output commit_trace_pkg::commit_rec_t [`COMMIT_LANES-1:0] lane_rec_o,
    output logic [`COMMIT_LANES-1:0][`LANE_CNT_W-1:0]         lane_cnt_o
);

    commit_trace_pkg::commit_rec_t [`COMMIT_LANES-1:0] stamped;

    commit_intake u_intake (
        .aclk        (aclk),
        .rst         (rst),
        .commit_i    (commit_i),
        .stamped_o   (stamped),
        .cycle_cnt_o (cycle_cnt_o)
    );

    generate
        for (genvar i = 0; i < `COMMIT_LANES; i++) begin : g_lane
            commit_lane u_lane (
                .aclk       (aclk),
                .rst        (rst),
                .rec_i      (stamped[i]),
                .rec_o      (lane_rec_o[i]),
                .lane_cnt_o (lane_cnt_o[i])
            );
        end
    endgenerate

    // reads the registered lanes
    commit_order u_order (
        .aclk          (aclk),
        .rst           (rst),
        .lane_i        (lane_rec_o),
        .order_index_o (order_index_o),
        .excp_o        (excp_o),
        .load_o        (load_o),
        .store_o       (store_o),
        .instr_cnt_o   (instr_cnt_o)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ns -f compile.f \
    --top-module commit_trace_tb -o commit_trace_sim

./obj_dir/commit_trace_sim | tee sim.log

if grep -q "^ALL TESTS PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== verif/commit_trace_tb_table.svh ====
`ifndef COMMIT_TRACE_TB_TABLE_SVH
`define COMMIT_TRACE_TB_TABLE_SVH

// columns: valid {lane1, lane0}, pc0, pc1, excp_flush {lane1, lane0},
// ld_en0, st_en0, ld_en1, st_en1, expected {index, excp valid, excp lane, ld en, st en}

localparam int TABLE_ROWS = 20;

row_t table_rows [TABLE_ROWS];

task automatic fill_table();
    // order index, lower and higher pc per lane, every mix of valid lanes
    table_rows[0]  = '{2'b11, 32'h100, 32'h104, 2'b00, 8'h00, 8'h00, 8'h00, 8'h00, 5'b00100};
    table_rows[1]  = '{2'b11, 32'h204, 32'h200, 2'b00, 8'h00, 8'h00, 8'h00, 8'h00, 5'b10000};
    table_rows[2]  = '{2'b01, 32'h300, 32'h000, 2'b00, 8'h00, 8'h00, 8'h00, 8'h00, 5'b00000};
    table_rows[3]  = '{2'b10, 32'h000, 32'h404, 2'b00, 8'h00, 8'h00, 8'h00, 8'h00, 5'b00100};
    table_rows[4]  = '{2'b10, 32'h508, 32'h500, 2'b00, 8'h00, 8'h00, 8'h00, 8'h00, 5'b10000};
    table_rows[5]  = '{2'b00, 32'h000, 32'h000, 2'b00, 8'h00, 8'h00, 8'h00, 8'h00, 5'b00000};
    table_rows[6]  = '{2'b00, 32'h010, 32'h020, 2'b00, 8'h00, 8'h00, 8'h00, 8'h00, 5'b00100};
    table_rows[7]  = '{2'b01, 32'h610, 32'h600, 2'b00, 8'h00, 8'h00, 8'h00, 8'h00, 5'b00000};

    // exception pick, lane 0 older
    table_rows[8]  = '{2'b11, 32'h700, 32'h704, 2'b01, 8'h00, 8'h00, 8'h00, 8'h00, 5'b01000};
    table_rows[9]  = '{2'b11, 32'h700, 32'h704, 2'b10, 8'h00, 8'h00, 8'h00, 8'h00, 5'b01100};
    table_rows[10] = '{2'b11, 32'h700, 32'h704, 2'b11, 8'h00, 8'h00, 8'h00, 8'h00, 5'b01000};
    // lane 1 older
    table_rows[11] = '{2'b11, 32'h804, 32'h800, 2'b01, 8'h00, 8'h00, 8'h00, 8'h00, 5'b11000};
    table_rows[12] = '{2'b11, 32'h804, 32'h800, 2'b10, 8'h00, 8'h00, 8'h00, 8'h00, 5'b11100};
    table_rows[13] = '{2'b11, 32'h804, 32'h800, 2'b11, 8'h00, 8'h00, 8'h00, 8'h00, 5'b11100};
    table_rows[14] = '{2'b11, 32'h900, 32'h900, 2'b00, 8'h00, 8'h00, 8'h00, 8'h00, 5'b10000};

    // memory events, lane 1 enables must not show up
    table_rows[15] = '{2'b11, 32'ha00, 32'ha04, 2'b00, 8'h0f, 8'h00, 8'h00, 8'h00, 5'b00110};
    table_rows[16] = '{2'b11, 32'hb00, 32'hb04, 2'b00, 8'h00, 8'hf0, 8'h00, 8'h00, 5'b00101};
    table_rows[17] = '{2'b11, 32'hc00, 32'hc04, 2'b00, 8'h00, 8'h00, 8'hff, 8'hff, 5'b00100};
    table_rows[18] = '{2'b01, 32'hd00, 32'hd04, 2'b00, 8'h01, 8'h80, 8'h03, 8'h0c, 5'b00111};
    table_rows[19] = '{2'b11, 32'he08, 32'he00, 2'b10, 8'h00, 8'h03, 8'hff, 8'h00, 5'b11101};
endtask

`endif

// ==== verif/commit_trace_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "commit_trace_macros.svh"

module commit_trace_tb;

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 8;
    localparam int RST_TIMEOUT  = 50;
    localparam int DRIVE_DELAY  = 1;
    localparam int BURST_ROWS   = 24;

    typedef struct packed {
        logic [1:0]           v;          // {lane 1, lane 0}
        logic [`XLEN-1:0]     pc0;
        logic [`XLEN-1:0]     pc1;
        logic [1:0]           fl;         // excp_flush per lane
        logic [`LSU_EN_W-1:0] ld0;
        logic [`LSU_EN_W-1:0] st0;
        logic [`LSU_EN_W-1:0] ld1;
        logic [`LSU_EN_W-1:0] st1;
        logic [4:0]           exp_bits;   // index, excp valid, excp lane, ld en, st en
    } row_t;

    `include "commit_trace_tb_table.svh"

    logic                                              aclk;
    logic                                              rst;
    commit_trace_pkg::commit_in_t  [`COMMIT_LANES-1:0] commit_i;
    logic [`TIMER_W-1:0]                               cycle_cnt;
    logic                                              order_index;
    commit_trace_pkg::excp_event_t                     excp;
    commit_trace_pkg::mem_event_t                      load_ev;
    commit_trace_pkg::mem_event_t                      store_ev;
    logic [`TIMER_W-1:0]                               instr_cnt;
    commit_trace_pkg::commit_rec_t [`COMMIT_LANES-1:0] lane_rec;
    logic [`COMMIT_LANES-1:0][`LANE_CNT_W-1:0]         lane_cnt;

    // reference state
    commit_trace_pkg::commit_rec_t exp_rec [`COMMIT_LANES];
    logic [`LANE_CNT_W-1:0]        exp_lane_cnt [`COMMIT_LANES];
    logic [`TIMER_W-1:0]           exp_instr;
    logic [`TIMER_W-1:0]           tb_cycle;
    logic [31:0]                   rng_state = 32'd10;
    int                            errors;
    int                            tests;
    int                            failed_tests;

    commit_trace_top uut (
        .aclk          (aclk),
        .rst           (rst),
        .commit_i      (commit_i),
        .cycle_cnt_o   (cycle_cnt),
        .order_index_o (order_index),
        .excp_o        (excp),
        .load_o        (load_ev),
        .store_o       (store_ev),
        .instr_cnt_o   (instr_cnt),
        .lane_rec_o    (lane_rec),
        .lane_cnt_o    (lane_cnt)
    );

    initial aclk = 1'b0;
    always #HALF_PERIOD aclk = ~aclk;

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge aclk);
        #DRIVE_DELAY;
        rst = 1'b0;
    end

    // mirrors the DUT timer
    always @(posedge aclk) begin
        if (rst) begin
            tb_cycle <= '0;
        end else begin
            tb_cycle <= tb_cycle + `TIMER_W'(1);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // stamped record as the backend fields should appear after one edge
    function automatic commit_trace_pkg::commit_rec_t to_record(
        input commit_trace_pkg::commit_in_t c, input logic [`TIMER_W-1:0] stamp);
        commit_trace_pkg::commit_rec_t r;
        r.valid        = c.valid;
        r.cnt_inst     = c.cnt_inst;
        r.pc           = c.pc;
        r.inst         = c.inst;
        r.rf_wen       = c.rf_wen;
        r.wdest        = `WDEST_W'(c.rf_wnum);   // unsigned cast, zero extends
        r.rf_wdata     = c.rf_wdata;
        r.ld_en        = c.ld_en;
        r.ld_paddr     = c.ld_paddr;
        r.ld_vaddr     = c.ld_vaddr;
        r.st_en        = c.st_en;
        r.st_paddr     = c.st_paddr;
        r.st_vaddr     = c.st_vaddr;
        r.st_data      = c.st_data;
        r.csr_rstat_en = c.csr_rstat_en;
        r.csr_data     = c.csr_data;
        r.excp_flush   = c.excp_flush;
        r.ertn         = c.ertn;
        r.ecode        = c.ecode;
        r.timer        = stamp;
        return r;
    endfunction

    task automatic check_rec(input string name, input commit_trace_pkg::commit_rec_t got,
                             input commit_trace_pkg::commit_rec_t exp);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_excp(input string name, input commit_trace_pkg::excp_event_t got,
                              input commit_trace_pkg::excp_event_t exp);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_mem(input string name, input commit_trace_pkg::mem_event_t got,
                             input commit_trace_pkg::mem_event_t exp);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input logic [`TIMER_W-1:0] got,
                               input logic [`TIMER_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s: got %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic drive_lane(input int lane, input logic valid, input logic [`XLEN-1:0] pc,
                              input logic flush, input logic [`LSU_EN_W-1:0] ld_en,
                              input logic [`LSU_EN_W-1:0] st_en);
        commit_trace_pkg::commit_in_t c;
        logic [31:0]                  r;
        r              = next_rand();
        c.valid        = valid;
        c.cnt_inst     = r[0];
        c.rf_wen       = r[1];
        c.csr_rstat_en = r[2];
        c.ertn         = r[3];
        c.rf_wnum      = r[8:4];
        c.ecode        = r[14:9];
        c.pc           = pc;
        c.inst         = next_rand();
        c.rf_wdata     = next_rand();
        c.ld_en        = ld_en;
        c.ld_paddr     = next_rand();
        c.ld_vaddr     = next_rand();
        c.st_en        = st_en;
        c.st_paddr     = next_rand();
        c.st_vaddr     = next_rand();
        c.st_data      = next_rand();
        c.csr_data     = next_rand();
        c.excp_flush   = flush;
        commit_i[lane] = c;
        exp_rec[lane]  = to_record(c, tb_cycle);   // timer before the sampling edge
        if (valid) begin
            exp_lane_cnt[lane] = exp_lane_cnt[lane] + `LANE_CNT_W'(1);
            exp_instr          = exp_instr + `TIMER_W'(1);
        end
    endtask

    task automatic apply_row(input row_t row);
        drive_lane(0, row.v[0], row.pc0, row.fl[0], row.ld0, row.st0);
        drive_lane(1, row.v[1], row.pc1, row.fl[1], row.ld1, row.st1);
    endtask

    task automatic check_records();
        for (int i = 0; i < `COMMIT_LANES; i++) begin
            check_rec($sformatf("lane_rec_o[%0d]", i), lane_rec[i], exp_rec[i]);
        end
    endtask

    task automatic check_lane_counts();
        for (int i = 0; i < `COMMIT_LANES; i++) begin
            check_count($sformatf("lane_cnt_o[%0d]", i), `TIMER_W'(lane_cnt[i]),
                        `TIMER_W'(exp_lane_cnt[i]));
        end
    endtask

    task automatic check_row(input row_t row);
        commit_trace_pkg::excp_event_t exp_excp;
        commit_trace_pkg::mem_event_t  exp_load;
        commit_trace_pkg::mem_event_t  exp_store;
        int                            pick;
        check_records();
        pick           = row.exp_bits[2] ? 1 : 0;
        exp_excp.valid = row.exp_bits[3];
        exp_excp.eret  = exp_rec[0].ertn;     // cause and eret stay on lane 0
        exp_excp.cause = exp_rec[0].ecode;
        exp_excp.pc    = exp_rec[pick].pc;
        exp_excp.inst  = exp_rec[pick].inst;
        exp_load.en     = row.exp_bits[1];
        exp_load.paddr  = exp_rec[0].ld_paddr;
        exp_load.vaddr  = exp_rec[0].ld_vaddr;
        exp_load.data   = '0;
        exp_store.en    = row.exp_bits[0];
        exp_store.paddr = exp_rec[0].st_paddr;
        exp_store.vaddr = exp_rec[0].st_vaddr;
        exp_store.data  = exp_rec[0].st_data;
        check_flag("order_index_o", order_index, row.exp_bits[4]);
        check_excp("excp_o", excp, exp_excp);
        check_mem("load_o", load_ev, exp_load);
        check_mem("store_o", store_ev, exp_store);
    endtask

    // one idle cycle lets instr_cnt_o catch up
    task automatic idle_and_check_counts();
        commit_i = '0;
        @(posedge aclk);
        #DRIVE_DELAY;
        check_count("instr_cnt_o", instr_cnt, exp_instr);
        check_count("cycle_cnt_o", cycle_cnt, tb_cycle);
        check_lane_counts();
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors > err_before) begin
            failed_tests++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    initial begin
        int                  wait_cnt;
        int                  err_before;
        row_t                row;
        logic [31:0]         r;
        logic [`TIMER_W-1:0] instr_before;
        commit_i     = '1;   // every lane busy, reset keeps it out of the records
        exp_instr    = '0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        for (int i = 0; i < `COMMIT_LANES; i++) begin
            exp_lane_cnt[i] = '0;
        end
        fill_table();

        // reset state with busy inputs
        @(posedge aclk);
        #DRIVE_DELAY;
        err_before = errors;
        for (int i = 0; i < `COMMIT_LANES; i++) begin
            check_rec($sformatf("lane_rec_o[%0d]", i), lane_rec[i], '0);
        end
        check_lane_counts();
        check_flag("excp_o.valid", excp.valid, 1'b0);
        check_flag("load_o.en", load_ev.en, 1'b0);
        check_flag("store_o.en", store_ev.en, 1'b0);
        check_count("instr_cnt_o", instr_cnt, '0);
        check_count("cycle_cnt_o", cycle_cnt, tb_cycle);
        report_test("reset state", err_before);
        commit_i = '0;

        wait_cnt = 0;
        while (rst !== 1'b0 && wait_cnt < RST_TIMEOUT) begin
            @(posedge aclk);
            wait_cnt++;
        end

        if (rst !== 1'b0) begin
            $display("reset still asserted after %0d cycles", RST_TIMEOUT);
            $display("SOME TESTS FAILED");
        end else begin
            #DRIVE_DELAY;

            // table rows back to back
            for (int n = 0; n < TABLE_ROWS; n++) begin
                err_before   = errors;
                instr_before = exp_instr;
                apply_row(table_rows[n]);
                @(posedge aclk);
                #DRIVE_DELAY;
                check_row(table_rows[n]);
                check_count("instr_cnt_o", instr_cnt, instr_before);   // one row behind
                check_lane_counts();
                report_test($sformatf("table row %0d", n), err_before);
            end
            err_before = errors;
            idle_and_check_counts();
            report_test("table counts", err_before);

            err_before = errors;
            for (int n = 0; n < BURST_ROWS; n++) begin
                r        = next_rand();
                row.v    = r[1:0];
                row.fl   = r[3:2];
                row.pc0  = next_rand();
                row.pc1  = next_rand();
                row.ld0  = r[4] ? `LSU_EN_W'(next_rand()) : '0;
                row.st0  = r[5] ? `LSU_EN_W'(next_rand()) : '0;
                row.ld1  = r[6] ? `LSU_EN_W'(next_rand()) : '0;
                row.st1  = r[7] ? `LSU_EN_W'(next_rand()) : '0;
                row.exp_bits = '0;   // only records and counts checked here
                apply_row(row);
                @(posedge aclk);
                #DRIVE_DELAY;
                check_records();
            end
            idle_and_check_counts();
            report_test("random burst", err_before);

            $display("%0d tests, %0d failed, %0d check errors", tests, failed_tests, errors);
            if (errors == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire
